/* rtl/reactionPkg.sv */
`default_nettype none

package reactionPkg;

    typedef enum logic [2:0] {
        Idle,
        Prep,
        Test,
        Result,
        Record
    } timerState_t;

    typedef enum logic [1:0] {
        Blank,
        Time,
        Fail
    } displayMode_t;

    // one count is one cycle of the 1 kHz clock
    typedef logic [13:0] msTime_t;

    // what the controller wants on the display
    typedef struct packed {
        displayMode_t mode;
        msTime_t      value;
    } displayReq_t;

    typedef struct packed {
        logic [3:0] thousands;
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
    } bcdDigits_t;

    // single-cycle press pulses
    typedef struct packed {
        logic start;
        logic stop;
        logic record;
    } buttonPress_t;

    localparam msTime_t MaxReactionMs = 14'd9999;
    localparam msTime_t ResultHoldMs  = 14'd10000;
    localparam msTime_t RecordHoldMs  = 14'd1000;
    localparam msTime_t NoRecord      = 14'd9999;

    // the letters sit right after the ten digits in the font table
    localparam logic [3:0] FontF = 4'd10;
    localparam logic [3:0] FontA = 4'd11;
    localparam logic [3:0] FontI = 4'd12;
    localparam logic [3:0] FontL = 4'd13;

    // active-low cathodes, bit order {g, f, e, d, c, b, a}
    localparam logic [6:0] SegmentFont [14] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000,
        7'b0001110, 7'b0001000, 7'b1001111, 7'b1000111
    };

endpackage

`default_nettype wire

/* rtl/buttonEdges.sv */
`timescale 1ns/1ps
`default_nettype none

module buttonEdges (
    input  wire logic                  clk_1kHz,
    input  wire logic                  resetFSM,
    input  wire logic                  start,
    input  wire logic                  stop,
    input  wire logic                  record,
    output reactionPkg::buttonPress_t  presses
);
    import reactionPkg::*;

    logic [2:0] syncFirst;
    logic [2:0] syncSecond;
    logic [2:0] previousLevel;

    // the buttons are asynchronous to the clock, so two flops come first
    // and a third keeps the last synchronized level for edge detection
    always_ff @(posedge clk_1kHz) begin
        if (resetFSM) begin
            syncFirst     <= 3'b000;
            syncSecond    <= 3'b000;
            previousLevel <= 3'b000;
            presses       <= '0;
        end else begin
            syncFirst     <= {start, stop, record};
            syncSecond    <= syncFirst;
            previousLevel <= syncSecond;
            presses       <= buttonPress_t'(syncSecond & ~previousLevel);
        end
    end

endmodule

`default_nettype wire

/* rtl/delayLfsr.sv */
`timescale 1ns/1ps
`default_nettype none

module delayLfsr #(
    parameter int PrepRandBits = 10
) (
    input  wire logic              clk_1kHz,
    input  wire logic              resetFSM,
    output logic [PrepRandBits-1:0] randomDelay
);

    localparam logic [15:0] Seed = 16'hACE1;

    logic [15:0] shiftReg;
    logic        feedback;

    // taps 16, 14, 13 and 11 give the maximal length of 65535 states,
    // and the all-zero state is never reached from a nonzero seed
    assign feedback = shiftReg[15] ^ shiftReg[13] ^ shiftReg[12] ^ shiftReg[10];

    always_ff @(posedge clk_1kHz) begin
        if (resetFSM) begin
            shiftReg <= Seed;
        end else begin
            shiftReg <= {shiftReg[14:0], feedback};
        end
    end

    // runs every cycle, so the value caught by the start press depends
    // on how long the player waited
    assign randomDelay = shiftReg[PrepRandBits-1:0];

endmodule

`default_nettype wire

/* rtl/reactionFsm.sv */
`timescale 1ns/1ps
`default_nettype none

module reactionFsm #(
    parameter int PrepBaseMs   = 1000,
    parameter int PrepRandBits = 10
) (
    input  wire logic                      clk_1kHz,
    input  wire logic                      resetFSM,
    input  wire reactionPkg::buttonPress_t presses,
    input  wire logic [PrepRandBits-1:0]   randomDelay,
    output logic                           testLed,
    output reactionPkg::displayReq_t       displayRequest
);
    import reactionPkg::*;

    timerState_t state;
    timerState_t nextState;
    msTime_t     msCount;
    msTime_t     elapsed;
    msTime_t     prepLength;
    msTime_t     reactionTime;
    msTime_t     bestTime;
    logic        failFlag;
    logic        leavingTest;

    // counts the current cycle too, so it equals the cycles spent in the state
    assign elapsed = msCount + 14'd1;

    ////////////////////////////////////////////////////////////////////////////
    // next state

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (presses.start) begin
                    nextState = Prep;
                end else if (presses.record) begin
                    nextState = Record;
                end
            end
            Prep: begin
                // an early stop is a fail and skips the test
                if (presses.stop) begin
                    nextState = Result;
                end else if (elapsed == prepLength) begin
                    nextState = Test;
                end
            end
            Test: begin
                if (presses.stop || elapsed == MaxReactionMs) begin
                    nextState = Result;
                end
            end
            Result: begin
                if (elapsed == ResultHoldMs) begin
                    nextState = Idle;
                end
            end
            Record: begin
                if (elapsed == RecordHoldMs) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    assign leavingTest = (state == Test) && (nextState == Result);

    ////////////////////////////////////////////////////////////////////////////
    // state, shared counter and best time

    always_ff @(posedge clk_1kHz) begin
        if (resetFSM) begin
            state    <= Idle;
            msCount  <= '0;
            failFlag <= 1'b0;
            bestTime <= NoRecord;
        end else begin
            state <= nextState;
            // one counter serves every state and restarts on each change
            if (nextState != state || state == Idle) begin
                msCount <= '0;
            end else begin
                msCount <= elapsed;
            end
            if (state == Prep && nextState == Result) begin
                failFlag <= 1'b1;
            end
            if (leavingTest) begin
                failFlag <= (elapsed >= MaxReactionMs);
                if (elapsed < MaxReactionMs && elapsed < bestTime) begin
                    bestTime <= elapsed;
                end
            end
        end
    end

    always_ff @(posedge clk_1kHz) begin
        if (state == Idle && nextState == Prep) begin
            prepLength <= msTime_t'(PrepBaseMs) + msTime_t'(randomDelay);
        end
        if (leavingTest) begin
            reactionTime <= elapsed;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs

    assign testLed = (state == Test);

    always_comb begin
        displayRequest.mode  = Blank;
        displayRequest.value = '0;
        case (state)
            Result: begin
                displayRequest.mode  = failFlag ? Fail : Time;
                displayRequest.value = reactionTime;
            end
            Record: begin
                // nothing to show until a valid run has set a best time
                displayRequest.mode  = (bestTime == NoRecord) ? Blank : Time;
                displayRequest.value = bestTime;
            end
            default: begin
                displayRequest.mode  = Blank;
                displayRequest.value = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/bcdConverter.sv */
`timescale 1ns/1ps
`default_nettype none

module bcdConverter (
    input  wire reactionPkg::msTime_t binary,
    output reactionPkg::bcdDigits_t   digits
);
    import reactionPkg::*;

    // four BCD digits above the fourteen binary bits
    logic [29:0] work;

    // double dabble, unrolled by the loops into a purely combinational net
    always_comb begin
        work = {16'd0, binary};
        for (int bitIdx = 0; bitIdx < 14; bitIdx++) begin
            for (int digitIdx = 0; digitIdx < 4; digitIdx++) begin
                // a digit of five or more would carry past nine after the shift
                if (work[14 + 4*digitIdx +: 4] >= 4'd5) begin
                    work[14 + 4*digitIdx +: 4] = work[14 + 4*digitIdx +: 4] + 4'd3;
                end
            end
            work = work << 1;
        end
    end

    // valid up to 9999; larger values overflow the thousands digit
    assign digits = bcdDigits_t'(work[29:14]);

endmodule

`default_nettype wire

/* rtl/displayScan.sv */
`timescale 1ns/1ps
`default_nettype none

module displayScan (
    input  wire logic                     clk_1kHz,
    input  wire logic                     resetFSM,
    input  wire reactionPkg::displayReq_t displayRequest,
    output logic [6:0]                    ssdCathode,
    output logic [3:0]                    ssdAnode,
    output logic                          dp
);
    import reactionPkg::*;

    logic [1:0] scanIndex;
    logic [3:0] fontIndex;
    logic [3:0] digitAnode;
    logic       failMode;
    bcdDigits_t digits;

    bcdConverter timeToBcd (
        .binary (displayRequest.value),
        .digits (digits)
    );

    assign failMode = (displayRequest.mode == Fail);

    // digit 3 is the leftmost, so FAIL reads F on 3 down to L on 0
    always_comb begin
        case (scanIndex)
            2'd0:    fontIndex = failMode ? FontL : digits.ones;
            2'd1:    fontIndex = failMode ? FontI : digits.tens;
            2'd2:    fontIndex = failMode ? FontA : digits.hundreds;
            default: fontIndex = failMode ? FontF : digits.thousands;
        endcase
    end

    assign digitAnode = ~(4'b0001 << scanIndex);

    always_ff @(posedge clk_1kHz) begin
        if (resetFSM) begin
            scanIndex <= 2'd0;
            ssdAnode  <= 4'hF;
            dp        <= 1'b1;
        end else begin
            scanIndex <= scanIndex + 2'd1;
            case (displayRequest.mode)
                Time: begin
                    ssdAnode <= digitAnode;
                    // the point after the thousands digit marks whole seconds
                    dp       <= (scanIndex != 2'd3);
                end
                Fail: begin
                    ssdAnode <= digitAnode;
                    dp       <= 1'b1;
                end
                default: begin
                    ssdAnode <= 4'hF;
                    dp       <= 1'b1;
                end
            endcase
        end
    end

    // cathodes only matter while an anode is low
    always_ff @(posedge clk_1kHz) begin
        ssdCathode <= SegmentFont[fontIndex];
    end

endmodule

`default_nettype wire

/* rtl/reactionTimerTop.sv */
`timescale 1ns/1ps
`default_nettype none

module reactionTimerTop #(
    parameter int PrepBaseMs   = 1000,
    parameter int PrepRandBits = 10
) (
    input  wire logic clk_1kHz,
    input  wire logic resetFSM,
    input  wire logic start,
    input  wire logic stop,
    input  wire logic record,
    output logic      testLed,
    output logic [6:0] ssdCathode,
    output logic [3:0] ssdAnode,
    output logic      dp
);
    import reactionPkg::*;

    buttonPress_t            presses;
    logic [PrepRandBits-1:0] randomDelay;
    displayReq_t             displayRequest;

    ////////////////////////////////////////////////////////////////////////////
    // inputs

    buttonEdges buttons (
        .clk_1kHz (clk_1kHz),
        .resetFSM (resetFSM),
        .start    (start),
        .stop     (stop),
        .record   (record),
        .presses  (presses)
    );

    delayLfsr #(
        .PrepRandBits (PrepRandBits)
    ) randomSource (
        .clk_1kHz    (clk_1kHz),
        .resetFSM    (resetFSM),
        .randomDelay (randomDelay)
    );

    ////////////////////////////////////////////////////////////////////////////
    // controller and display

    reactionFsm #(
        .PrepBaseMs   (PrepBaseMs),
        .PrepRandBits (PrepRandBits)
    ) controller (
        .clk_1kHz       (clk_1kHz),
        .resetFSM       (resetFSM),
        .presses        (presses),
        .randomDelay    (randomDelay),
        .testLed        (testLed),
        .displayRequest (displayRequest)
    );

    displayScan display (
        .clk_1kHz       (clk_1kHz),
        .resetFSM       (resetFSM),
        .displayRequest (displayRequest),
        .ssdCathode     (ssdCathode),
        .ssdAnode       (ssdAnode),
        .dp             (dp)
    );

endmodule

`default_nettype wire

/* testbench/reactionTasks.svh */
// reports one failure and ends the run
task automatic stopWithFailure(input string reason);
    errorCount++;
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first failure");
endtask

task automatic checkValue(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
        stopWithFailure($sformatf("[ERROR] %s: expected 0x%0h, got 0x%0h",
                                  name, expected, actual));
    end
endtask

// holds the chosen buttons for exactly one rising edge
task automatic pressButtons(input buttonPress_t which);
    {start, stop, record} = which;
    @(negedge clk_1kHz);
    {start, stop, record} = 3'b000;
endtask

task automatic waitForLed(input logic level, input int limit);
    int waited;
    waited = 0;
    while (testLed !== level) begin
        if (waited >= limit) begin
            stopWithFailure($sformatf("testLed did not change to %0b within %0d cycles",
                                      level, limit));
        end
        @(negedge clk_1kHz);
        waited++;
    end
endtask

// the lamp must stay dark while the result is shown
task automatic waitForBlank(input int limit);
    int waited;
    waited = 0;
    while (ssdAnode !== 4'hF) begin
        checkValue("testLed", 32'(testLed), 32'd0);
        if (waited >= limit) begin
            stopWithFailure($sformatf("display did not go blank within %0d cycles", limit));
        end
        @(negedge clk_1kHz);
        waited++;
    end
endtask

function automatic logic [3:0] fontIndexOf(input logic [6:0] pattern);
    logic [3:0] found;
    found = 4'hF;
    for (int i = 0; i < 14; i++) begin
        if (SegmentFont[i] == pattern) begin
            found = 4'(i);
        end
    end
    return found;
endfunction

function automatic logic [15:0] decimalSymbols(input int value);
    return {4'(value / 1000 % 10), 4'(value / 100 % 10), 4'(value / 10 % 10), 4'(value % 10)};
endfunction

// one pass over the four scan positions, digit 3 lands in the top nibble
task automatic expectDisplay(input logic [15:0] symbols, input logic [3:0] lit,
                             input logic [3:0] points);
    logic [15:0] seenSymbols;
    logic [3:0]  seenLit;
    logic [3:0]  seenPoints;
    seenSymbols = '0;
    seenLit     = '0;
    seenPoints  = '0;
    repeat (4) begin
        @(negedge clk_1kHz);
        if (ssdAnode !== 4'hF) begin
            checkValue("ssdAnode low count", $countones(~ssdAnode), 32'd1);
        end
        for (int p = 0; p < 4; p++) begin
            if (ssdAnode[p] === 1'b0) begin
                seenSymbols[4*p +: 4] = fontIndexOf(ssdCathode);
                seenLit[p]            = 1'b1;
                seenPoints[p]         = ~dp;
            end
        end
    end
    checkValue("ssdAnode digits", 32'(seenLit), 32'(lit));
    checkValue("ssdCathode symbols", 32'(seenSymbols), 32'(symbols));
    checkValue("dp digits", 32'(seenPoints), 32'(points));
endtask

task automatic verifyResetState();
    repeat (100) begin
        @(negedge clk_1kHz);
        checkValue("testLed", 32'(testLed), 32'd0);
        checkValue("ssdAnode", 32'(ssdAnode), 32'hF);
        checkValue("dp", 32'(dp), 32'd1);
    end
endtask

task automatic showRecord(input logic shown, input int best);
    pressButtons(RecordPress);
    waitCycles(PressToState + DisplayLag);
    if (shown) begin
        expectDisplay(decimalSymbols(best), 4'b1111, 4'b1000);
    end else begin
        expectDisplay(16'h0000, 4'b0000, 4'b0000);
    end
    waitCycles(int'(RecordHoldMs));
    checkValue("ssdAnode", 32'(ssdAnode), 32'hF);
endtask

task automatic waitCycles(input int count);
    repeat (count) @(negedge clk_1kHz);
endtask

// reads the result once, then times how long it stays up
task automatic checkResult(input logic [15:0] symbols, input logic [3:0] points,
                           input int resultStart);
    while (cycleCount < resultStart + DisplayLag) begin
        @(negedge clk_1kHz);
    end
    expectDisplay(symbols, 4'b1111, points);
    waitForBlank(int'(ResultHoldMs) + 8);
    checkValue("result hold cycles", cycleCount - resultStart, int'(ResultHoldMs) + DisplayLag);
endtask

////////////////////////////////////////////////////////////////////////////
// directed runs

task automatic runValid(input int reactionWait, output int reactionMs);
    int pressCycle;
    int testStart;
    int prepCycles;
    int expectedMs;
    int maxPrep;
    maxPrep = PrepBaseMs + (1 << PrepRandBits) - 1;
    pressButtons(StartPress);
    pressCycle = cycleCount;
    waitForLed(1'b1, maxPrep + PressToState + 1);
    testStart  = cycleCount;
    prepCycles = testStart - pressCycle - PressToState;
    if (prepCycles < PrepBaseMs || prepCycles > maxPrep) begin
        stopWithFailure($sformatf("[ERROR] preparation cycles: 0x%0h outside 0x%0h to 0x%0h",
                                  prepCycles, PrepBaseMs, maxPrep));
    end
    repeat (reactionWait) begin
        @(negedge clk_1kHz);
        checkValue("testLed", 32'(testLed), 32'd1);
    end
    pressButtons(StopPress);
    expectedMs = cycleCount - testStart + PressToState;
    waitForLed(1'b0, PressToState + 1);
    reactionMs = cycleCount - testStart;
    checkValue("reaction time", reactionMs, expectedMs);
    checkResult(decimalSymbols(reactionMs), 4'b1000, cycleCount);
endtask

// stop while the lamp is still dark
task automatic runEarlyStop(input int stopWait);
    pressButtons(StartPress);
    repeat (stopWait) begin
        @(negedge clk_1kHz);
        checkValue("testLed", 32'(testLed), 32'd0);
    end
    pressButtons(StopPress);
    checkResult(FailSymbols, 4'b0000, cycleCount + PressToState);
endtask

task automatic runOverflow();
    int testStart;
    pressButtons(StartPress);
    waitForLed(1'b1, PrepBaseMs + (1 << PrepRandBits) + PressToState);
    testStart = cycleCount;
    waitForLed(1'b0, int'(MaxReactionMs) + 1);
    checkValue("testLed high cycles", cycleCount - testStart, int'(MaxReactionMs));
    checkResult(FailSymbols, 4'b0000, cycleCount);
endtask

/* testbench/reactionTimerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module reactionTimerTb;
    import reactionPkg::*;

    localparam int PrepBaseMs   = 1000;
    localparam int PrepRandBits = 10;
    localparam int ClockPeriod  = 40;
    localparam int ResetCycles  = 16;

    // a sampled press takes two cycles to become a pulse and one more to move the FSM
    localparam int PressToState = 3;
    // the display registers its lines one cycle behind the controller
    localparam int DisplayLag   = 1;

    localparam int RunBudget = PrepBaseMs + (1 << PrepRandBits) + int'(MaxReactionMs)
                             + int'(ResultHoldMs);

    localparam buttonPress_t StartPress  = '{start: 1'b1, stop: 1'b0, record: 1'b0};
    localparam buttonPress_t StopPress   = '{start: 1'b0, stop: 1'b1, record: 1'b0};
    localparam buttonPress_t RecordPress = '{start: 1'b0, stop: 1'b0, record: 1'b1};

    // digit 3 down to digit 0
    localparam logic [15:0] FailSymbols = {FontF, FontA, FontI, FontL};

    logic        clk_1kHz;
    logic        resetFSM;
    logic        start;
    logic        stop;
    logic        record;
    logic        testLed;
    logic [6:0]  ssdCathode;
    logic [3:0]  ssdAnode;
    logic        dp;

    int          cycleCount;
    int          errorCount;
    logic [31:0] lfsrState;

    reactionTimerTop #(
        .PrepBaseMs   (PrepBaseMs),
        .PrepRandBits (PrepRandBits)
    ) DUT (
        .clk_1kHz   (clk_1kHz),
        .resetFSM   (resetFSM),
        .start      (start),
        .stop       (stop),
        .record     (record),
        .testLed    (testLed),
        .ssdCathode (ssdCathode),
        .ssdAnode   (ssdAnode),
        .dp         (dp)
    );

    always #(ClockPeriod / 2) clk_1kHz = ~clk_1kHz;

    // free-running count of rising edges, read on the falling edge to time each phase
    always @(posedge clk_1kHz) begin
        cycleCount <= cycleCount + 1;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] result;
        logic        feedback;
        result = '0;
        for (int i = 0; i < count; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            result    = {result[30:0], feedback};
        end
        return result;
    endfunction

    `include "reactionTasks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // watchdog and test sequence

    // the budget covers six complete runs, more than the sequence needs
    initial begin
        #(longint'(6 * RunBudget) * ClockPeriod);
        stopWithFailure("watchdog timeout, the test sequence did not finish in time");
    end

    initial begin
        int t1;
        int t2;
        int t3;
        clk_1kHz   = 1'b0;
        resetFSM   = 1'b1;
        start      = 1'b0;
        stop       = 1'b0;
        record     = 1'b0;
        cycleCount = 0;
        errorCount = 0;
        lfsrState  = 32'h39aa;
        repeat (ResetCycles) @(negedge clk_1kHz);
        resetFSM = 1'b0;

        verifyResetState();
        showRecord(1'b0, 0);
        runValid(300 + randomBits(8), t1);
        showRecord(1'b1, t1);
        // a longer wait makes a slower run that must leave the best time alone
        runValid(t1 + 200 + randomBits(8), t2);
        showRecord(1'b1, t1);
        runEarlyStop(20 + randomBits(7));
        showRecord(1'b1, t1);
        runOverflow();
        runValid(20 + randomBits(6), t3);
        showRecord(1'b1, t3);

        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* reactionTimerTop.f */
+incdir+testbench
rtl/reactionPkg.sv
rtl/buttonEdges.sv
rtl/delayLfsr.sv
rtl/reactionFsm.sv
rtl/bcdConverter.sv
rtl/displayScan.sv
rtl/reactionTimerTop.sv
testbench/reactionTimerTb.sv

/* Makefile */
TB := reactionTimerTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f reactionTimerTop.f --top-module reactionTimerTop

# the run passes only when the pass line shows up in the simulator output
sim:
	verilator --binary --timing -f reactionTimerTop.f --top-module $(TB) -Mdir obj_dir
	./obj_dir/V$(TB) | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
